// ==== calc_top.f ====
+incdir+common
common/calc_isa_pkg.sv
common/calc_pipe_pkg.sv
exec/calc_alu.sv
exec/calc_mul.sv
verilog/calc_issue.sv
verilog/calc_completion.sv
verilog/calc_top.sv
tests/tb_clock_gen.sv
tests/calc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the calculator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module calc_tb -f calc_top.f -Mdir obj_dir

out=$(./obj_dir/Vcalc_tb)
echo "$out"

if echo "$out" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1

// ==== tests/calc_tb.sv ====
// ========================================
// Testbench for the calculator back end
// Directed and random dispatch streams,
// program-order reference model, flushes,
// writeback compare and watchdog
// ========================================

`timescale 1ns/10ps

`include "calc_macros.svh"

module calc_tb;

  localparam int CLK_PERIOD_NS = 4;
  localparam int N_REGS        = 1 << `CALC_REG_ADDR_W;
  localparam int N_IDLE        = 8;
  localparam int N_ISO         = 9 * 2 * 4;
  localparam int N_DEP         = 40;
  localparam int N_MIX         = 200;
  localparam int N_FLUSH       = 120;
  localparam int N_NOWR        = 40;
  localparam int N_DRAIN       = 6;
  localparam int N_SLOTS       = N_IDLE + N_ISO + N_DEP + N_MIX + N_FLUSH + N_NOWR + N_DRAIN;

  // One dispatched item while it can still be flushed
  typedef struct packed
  {
    logic                         v;
    logic                         poison;
    logic                         wr;
    calc_isa_pkg::calc_reg_addr_t rd;
    calc_isa_pkg::calc_data_t     res;
  } flight_s;

  // Writeback due at a given rising edge
  typedef struct packed
  {
    logic [31:0]                  due;
    calc_isa_pkg::calc_reg_addr_t rd;
    calc_isa_pkg::calc_data_t     data;
  } exp_wb_s;

  logic                          clk;
  logic                          arst_n;
  calc_pipe_pkg::calc_dispatch_s dispatch;
  logic                          flush;
  calc_pipe_pkg::calc_wb_s       wb;

  integer                        seed = 53289;
  int                            edge_cnt = 0;
  logic                          running;
  int                            err_data;
  int                            err_addr;
  int                            err_valid;
  calc_isa_pkg::calc_data_t      arch_rf [N_REGS];
  calc_isa_pkg::calc_data_t      ref_rf [N_REGS];
  flight_s                       flight [8];
  exp_wb_s                       exp_q [$];
  exp_wb_s                       cur_exp;
  calc_isa_pkg::calc_reg_addr_t  blocked;
  calc_isa_pkg::calc_reg_addr_t  last_rd [2];

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RST_CYCLES(2)) u_clk_gen
  (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  calc_top UUT
  (
    .clk_i      (clk),
    .arst_n_i   (arst_n),
    .dispatch_i (dispatch),
    .flush_i    (flush),
    .wb_o       (wb)
  );

  always @(posedge clk) edge_cnt <= edge_cnt + 1;

  function automatic int rand_below(input int n);
    int unsigned r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  // Result of one operation as the ISA defines it
  function automatic calc_isa_pkg::calc_data_t ref_result
  (
    input calc_isa_pkg::calc_op_e op,
    input calc_isa_pkg::calc_data_t a,
    input calc_isa_pkg::calc_data_t b
  );
    logic [2*`CALC_DATA_W-1:0] prod;
    logic                      less;
    prod = {{`CALC_DATA_W{1'b0}}, a} * {{`CALC_DATA_W{1'b0}}, b};
    // With differing signs the negative one is less
    less = (a[`CALC_DATA_W-1] != b[`CALC_DATA_W-1]) ? a[`CALC_DATA_W-1] : (a < b);
    case (op)
      calc_isa_pkg::OP_ADD: return a + b;
      calc_isa_pkg::OP_SUB: return a - b;
      calc_isa_pkg::OP_AND: return a & b;
      calc_isa_pkg::OP_OR:  return a | b;
      calc_isa_pkg::OP_XOR: return a ^ b;
      calc_isa_pkg::OP_SLT: return calc_isa_pkg::calc_data_t'(less);
      calc_isa_pkg::OP_SLL: return a << b[4:0];
      calc_isa_pkg::OP_SRL: return a >> b[4:0];
      calc_isa_pkg::OP_MUL: return prod[`CALC_DATA_W-1:0];
      default:              return '0;
    endcase
  endfunction

  // Program-order value of a register as seen by the item at edge e
  function automatic calc_isa_pkg::calc_data_t src_value
  (
    input calc_isa_pkg::calc_reg_addr_t addr,
    input int                           e
  );
    calc_isa_pkg::calc_data_t v;
    flight_s                  f;
    v = ref_rf[addr];
    for (int k = 2; k >= 1; k--)
    begin
      f = flight[(e - k) % 8];
      if (f.v && f.wr && !f.poison && (f.rd == addr))
        v = f.res;
    end
    if (addr == '0)
      v = '0;
    return v;
  endfunction

  task automatic check_wb_data(input calc_isa_pkg::calc_data_t got,
                               input calc_isa_pkg::calc_data_t exp);
    if (got !== exp)
    begin
      err_data++;
      $display("Mismatch wb_o.rd_data at edge %0d: got %h, expected %h", edge_cnt, got, exp);
    end
  endtask

  task automatic check_wb_addr(input calc_isa_pkg::calc_reg_addr_t got,
                               input calc_isa_pkg::calc_reg_addr_t exp);
    if (got !== exp)
    begin
      err_addr++;
      $display("Mismatch wb_o.rd_addr at edge %0d: got %h, expected %h", edge_cnt, got, exp);
    end
  endtask

  task automatic check_wb_valid(input logic got, input logic exp);
    if (got !== exp)
    begin
      err_valid++;
      $display("Mismatch wb_o.rd_w_v at edge %0d: got %h, expected %h", edge_cnt, got, exp);
    end
  endtask

  // Drive one dispatch slot and advance the reference model
  task automatic run_slot(input calc_pipe_pkg::calc_dispatch_s pkt, input logic fl);
    int                       e;
    flight_s                  old;
    flight_s                  cur;
    exp_wb_s                  item;
    calc_isa_pkg::calc_data_t b;
    @(negedge clk);
    e = edge_cnt + 1;
    if (wb.rd_w_v && (wb.rd_addr != '0))
      arch_rf[wb.rd_addr] = wb.rd_data;
    // Item from three edges back is past any flush
    old = flight[(e - 3) % 8];
    if (old.v && old.wr && !old.poison)
    begin
      if (old.rd != '0)
        ref_rf[old.rd] = old.res;
      item.due  = e;
      item.rd   = old.rd;
      item.data = old.res;
      exp_q.push_back(item);
    end
    if (fl)
    begin
      flight[(e - 1) % 8].poison = 1'b1;
      flight[(e - 2) % 8].poison = 1'b1;
    end
    b          = pkt.use_imm ? pkt.imm : src_value(pkt.rs2_addr, e);
    cur.v      = pkt.valid;
    cur.poison = fl;
    cur.wr     = pkt.rd_w_v;
    cur.rd     = pkt.rd_addr;
    cur.res    = ref_result(pkt.op, src_value(pkt.rs1_addr, e), b);
    flight[e % 8] = cur;
    // DUT gets register file values and forwards the rest
    pkt.rs1  = arch_rf[pkt.rs1_addr];
    pkt.rs2  = arch_rf[pkt.rs2_addr];
    dispatch = pkt;
    flush    = fl;
    blocked  = (pkt.valid && pkt.rd_w_v && (pkt.op == calc_isa_pkg::OP_MUL)) ? pkt.rd_addr : '0;
    if (pkt.valid)
    begin
      last_rd[1] = last_rd[0];
      last_rd[0] = pkt.rd_addr;
    end
  endtask

  // Random slot with sources chained to the latest destinations when dep is set
  task automatic gen_slot(input logic dep, input int span, input int wr_odds, input logic flushes);
    calc_pipe_pkg::calc_dispatch_s pkt;
    logic                          fl;
    pkt         = '0;
    pkt.valid   = dep || (rand_below(4) != 0);
    pkt.op      = calc_isa_pkg::calc_op_e'(rand_below(9));
    pkt.use_imm = !dep && (rand_below(4) == 0);
    pkt.imm     = $random(seed);
    pkt.rd_addr = calc_isa_pkg::calc_reg_addr_t'(dep ? 1 + rand_below(span - 1)
                                                     : rand_below(span));
    pkt.rd_w_v  = (rand_below(wr_odds) != 0);
    if (dep)
    begin
      pkt.rs1_addr = (last_rd[0] != blocked) ? last_rd[0] : last_rd[1];
      pkt.rs2_addr = last_rd[1];
    end
    else
    begin
      pkt.rs1_addr = calc_isa_pkg::calc_reg_addr_t'(rand_below(span));
      pkt.rs2_addr = calc_isa_pkg::calc_reg_addr_t'(rand_below(span));
    end
    // Last cycle's product cannot be read yet
    if ((blocked != '0) && (pkt.rs1_addr == blocked))
      pkt.rs1_addr = '0;
    if ((blocked != '0) && (pkt.rs2_addr == blocked))
      pkt.rs2_addr = '0;
    fl = flushes && (rand_below(8) == 0);
    run_slot(pkt, fl);
  endtask

  always @(negedge clk)
  begin
    if (arst_n && running)
    begin
      if ((exp_q.size() > 0) && (exp_q[0].due == edge_cnt))
      begin
        cur_exp = exp_q.pop_front();
        check_wb_valid(wb.rd_w_v, 1'b1);
        check_wb_addr(wb.rd_addr, cur_exp.rd);
        check_wb_data(wb.rd_data, cur_exp.data);
      end
      else
      begin
        check_wb_valid(wb.rd_w_v, 1'b0);
      end
    end
  end

  initial
  begin
    calc_pipe_pkg::calc_dispatch_s pkt;
    dispatch   = '0;
    flush      = 1'b0;
    running    = 1'b0;
    err_data   = 0;
    err_addr   = 0;
    err_valid  = 0;
    blocked    = '0;
    last_rd[0] = '0;
    last_rd[1] = '0;
    for (int i = 0; i < 8; i++)
      flight[i] = '0;
    arch_rf[0] = '0;
    for (int r = 1; r < N_REGS; r++)
      arch_rf[r] = $random(seed);
    ref_rf = arch_rf;
    wait (arst_n);
    @(posedge clk);
    running = 1'b1;

    repeat (N_IDLE) run_slot('0, 1'b0);
    // Every operation alone in register and immediate form
    for (int op = 0; op < 9; op++)
    begin
      for (int imm = 0; imm < 2; imm++)
      begin
        pkt          = '0;
        pkt.valid    = 1'b1;
        pkt.op       = calc_isa_pkg::calc_op_e'(op);
        pkt.use_imm  = (imm != 0);
        pkt.rs1_addr = calc_isa_pkg::calc_reg_addr_t'(1 + rand_below(7));
        pkt.rs2_addr = calc_isa_pkg::calc_reg_addr_t'(1 + rand_below(7));
        pkt.rd_addr  = calc_isa_pkg::calc_reg_addr_t'(1 + rand_below(7));
        pkt.imm      = $random(seed);
        pkt.rd_w_v   = 1'b1;
        run_slot(pkt, 1'b0);
        repeat (3) run_slot('0, 1'b0);
      end
    end
    repeat (N_DEP) gen_slot(1'b1, 8, 1000, 1'b0);
    repeat (N_MIX) gen_slot(1'b0, 8, 5, 1'b0);
    repeat (N_FLUSH) gen_slot(1'b0, 8, 5, 1'b1);
    // Narrow register range with many non-writers and writes to register 0
    repeat (N_NOWR) gen_slot(1'b0, 3, 2, 1'b0);
    repeat (N_DRAIN) run_slot('0, 1'b0);

    @(posedge clk);
    running = 1'b0;
    $display("Errors: rd_data %0d, rd_addr %0d, rd_w_v %0d", err_data, err_addr, err_valid);
    if ((err_data + err_addr + err_valid) == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

  // Watchdog sized from the stimulus length
  initial
  begin
    #((N_SLOTS + 20) * CLK_PERIOD_NS);
    $display("Timeout after %0d ns, the stimulus did not complete",
             (N_SLOTS + 20) * CLK_PERIOD_NS);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== tests/tb_clock_gen.sv ====
// ========================================
// Testbench clock and reset generator
// Free running clock, reset held low for
// a number of cycles after time zero
// ========================================

`timescale 1ns/10ps

module tb_clock_gen
#(
  parameter int PERIOD_NS  = 4,
  parameter int RST_CYCLES = 2
)
(
  output logic clk_o,
  output logic arst_n_o
);

  initial
  begin
    clk_o    = 1'b0;
    arst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    // Release away from the rising edge
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

// ==== verilog/calc_top.sv ====
// ========================================
// Calculator back end top level
// Issue, integer and multiply pipes,
// completion pipe
// ========================================

`timescale 1ns/10ps

`include "calc_macros.svh"

module calc_top
(
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  calc_pipe_pkg::calc_dispatch_s dispatch_i,
  input  logic                          flush_i,
  output calc_pipe_pkg::calc_wb_s       wb_o
);

  calc_pipe_pkg::calc_dispatch_s                   res;
  calc_pipe_pkg::calc_stage_info_s                 isd;
  calc_pipe_pkg::calc_fwd_s    [`CALC_STAGES-1:0] fwd;
  calc_isa_pkg::calc_data_t                        int_data;
  calc_isa_pkg::calc_data_t                        mul_data;

  calc_issue u_issue
  (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .dispatch_i (dispatch_i),
    .fwd_i      (fwd),
    .res_o      (res),
    .isd_o      (isd)
  );

  // 1 cycle pipe
  calc_alu u_alu
  (
    .res_i      (res),
    .int_data_o (int_data)
  );

  // 2 cycle pipe
  calc_mul u_mul
  (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .res_i      (res),
    .mul_data_o (mul_data)
  );

  calc_completion u_completion
  (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .isd_i      (isd),
    .int_data_i (int_data),
    .mul_data_i (mul_data),
    .flush_i    (flush_i),
    .fwd_o      (fwd),
    .wb_o       (wb_o)
  );

endmodule

// ==== verilog/calc_completion.sv ====
// ========================================
// Completion pipe
// Stage info, poison and result shifting,
// forwarding slots and writeback register
// ========================================

`timescale 1ns/10ps

`include "calc_macros.svh"

module calc_completion
(
  input  logic                                        clk_i,
  input  logic                                        arst_n_i,
  input  calc_pipe_pkg::calc_stage_info_s             isd_i,
  input  calc_isa_pkg::calc_data_t                    int_data_i,
  input  calc_isa_pkg::calc_data_t                    mul_data_i,
  input  logic                                        flush_i,
  output calc_pipe_pkg::calc_fwd_s [`CALC_STAGES-1:0] fwd_o,
  output calc_pipe_pkg::calc_wb_s                     wb_o
);

  // Stage where the product becomes available
  localparam int MUL_STAGE = 1;

  calc_pipe_pkg::calc_stage_info_s [`CALC_STAGES-1:0]   info_r;
  logic                            [`CALC_STAGES-1:0]   poison_r;
  logic                            [`CALC_STAGES-1:0]   poison_n;
  logic                            [`CALC_STAGES-1:0]   kill;
  calc_isa_pkg::calc_data_t        [`CALC_STAGES-1:0]   data_n;
  calc_isa_pkg::calc_data_t        [`CALC_WB_STAGE-1:0] data_r;
  calc_pipe_pkg::calc_wb_s                              wb_n;
  calc_pipe_pkg::calc_wb_s                              wb_r;

  // Flush poisons everything still upstream of writeback
  always_comb
  begin
    poison_n[0] = flush_i;
    for (int k = 1; k < `CALC_STAGES; k++)
    begin
      poison_n[k] = poison_r[k-1] | flush_i;
    end
    for (int k = 0; k < `CALC_STAGES; k++)
    begin
      kill[k] = poison_r[k] | (flush_i && (k < `CALC_WB_STAGE));
    end
  end

  // Result mux per stage
  always_comb
  begin
    data_n[0] = int_data_i;
    data_n[MUL_STAGE] = info_r[MUL_STAGE].mul_v ? mul_data_i : data_r[MUL_STAGE-1];
    for (int k = MUL_STAGE + 1; k < `CALC_STAGES; k++)
    begin
      data_n[k] = data_r[k-1];
    end
  end

  // Forwarding slots are the next-state values of each stage
  always_comb
  begin
    for (int k = 0; k < `CALC_STAGES; k++)
    begin
      fwd_o[k].rd_v    = info_r[k].valid && info_r[k].rd_w_v && !kill[k]
                         && !((k < MUL_STAGE) && info_r[k].mul_v);
      fwd_o[k].rd_addr = info_r[k].rd_addr;
      fwd_o[k].rd_data = data_n[k];
    end
  end

  // Writeback takes the last slot as is
  always_comb
  begin
    wb_n.rd_w_v  = fwd_o[`CALC_WB_STAGE].rd_v;
    wb_n.rd_addr = fwd_o[`CALC_WB_STAGE].rd_addr;
    wb_n.rd_data = fwd_o[`CALC_WB_STAGE].rd_data;
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      info_r   <= '0;
      poison_r <= '0;
      wb_r     <= '0;
    end
    else
    begin
      info_r   <= {info_r[`CALC_STAGES-2:0], isd_i};
      poison_r <= poison_n;
      wb_r     <= wb_n;
    end
  end

  always_ff @(posedge clk_i)
  begin
    data_r <= data_n[`CALC_WB_STAGE-1:0];
  end

  assign wb_o = wb_r;

  // Each item takes its result from exactly one pipe
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (info_r[MUL_STAGE].valid && info_r[MUL_STAGE].mul_v)
    |-> !$past(info_r[MUL_STAGE-1].int_v));

endmodule

// ==== verilog/calc_issue.sv ====
// ========================================
// Input side of the calculator
// Operand forwarding, reservation register
// and stage info for the completion pipe
// ========================================

`timescale 1ns/10ps

`include "calc_macros.svh"

module calc_issue
(
  input  logic                                        clk_i,
  input  logic                                        arst_n_i,
  input  calc_pipe_pkg::calc_dispatch_s               dispatch_i,
  input  calc_pipe_pkg::calc_fwd_s [`CALC_STAGES-1:0] fwd_i,
  output calc_pipe_pkg::calc_dispatch_s               res_o,
  output calc_pipe_pkg::calc_stage_info_s             isd_o
);

  calc_pipe_pkg::calc_dispatch_s res_n;
  calc_pipe_pkg::calc_dispatch_s res_r;

  // Walk oldest to youngest so the youngest hit wins
  function automatic calc_isa_pkg::calc_data_t fwd_operand
  (
    input calc_isa_pkg::calc_reg_addr_t               addr,
    input calc_isa_pkg::calc_data_t                   data,
    input calc_pipe_pkg::calc_fwd_s [`CALC_STAGES-1:0] fwd
  );
    calc_isa_pkg::calc_data_t result;
    result = data;
    for (int i = `CALC_STAGES-1; i >= 0; i--)
    begin
      if (fwd[i].rd_v && (fwd[i].rd_addr == addr) && (addr != '0))
      begin
        result = fwd[i].rd_data;
      end
    end
    return result;
  endfunction

  always_comb
  begin
    res_n     = dispatch_i;
    res_n.rs1 = fwd_operand(dispatch_i.rs1_addr, dispatch_i.rs1, fwd_i);
    res_n.rs2 = fwd_operand(dispatch_i.rs2_addr, dispatch_i.rs2, fwd_i);
  end

  // Control bits for the completion pipe, enters stage 0 with the packet
  always_comb
  begin
    isd_o.valid   = dispatch_i.valid;
    isd_o.int_v   = dispatch_i.valid && (dispatch_i.op != calc_isa_pkg::OP_MUL);
    isd_o.mul_v   = dispatch_i.valid && (dispatch_i.op == calc_isa_pkg::OP_MUL);
    isd_o.rd_w_v  = dispatch_i.valid && dispatch_i.rd_w_v;
    isd_o.rd_addr = dispatch_i.rd_addr;
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      res_r <= '0;
    end
    else
    begin
      res_r <= res_n;
    end
  end

  assign res_o = res_r;

  // Product of last cycle's multiply is not forwardable yet
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (dispatch_i.valid && res_r.valid && (res_r.op == calc_isa_pkg::OP_MUL)
     && res_r.rd_w_v && (res_r.rd_addr != '0))
    |-> (dispatch_i.rs1_addr != res_r.rd_addr));

endmodule

// ==== exec/calc_mul.sv ====
// ========================================
// Multiply pipe, two cycle latency
// Low word of rs1 times operand b
// ========================================

`timescale 1ns/10ps

module calc_mul
(
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  calc_pipe_pkg::calc_dispatch_s res_i,
  output calc_isa_pkg::calc_data_t      mul_data_o
);

  calc_isa_pkg::calc_data_t op_b;
  calc_isa_pkg::calc_data_t product;

  assign op_b    = res_i.use_imm ? res_i.imm : res_i.rs2;
  // Only the low word is kept
  assign product = res_i.rs1 * op_b;

  // Second cycle of latency, hold when idle
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      mul_data_o <= '0;
    end
    else if (res_i.valid)
    begin
      mul_data_o <= product;
    end
  end

endmodule

// ==== exec/calc_alu.sv ====
// ========================================
// Integer pipe, single cycle
// Add, sub, logic, compare and shifts
// ========================================

`timescale 1ns/10ps

module calc_alu
(
  input  calc_pipe_pkg::calc_dispatch_s res_i,
  output calc_isa_pkg::calc_data_t      int_data_o
);

  calc_isa_pkg::calc_data_t op_b;
  logic [4:0]               shamt;
  logic                     slt;

  // Second operand is either the immediate or rs2
  assign op_b  = res_i.use_imm ? res_i.imm : res_i.rs2;
  assign shamt = op_b[4:0];
  assign slt   = $signed(res_i.rs1) < $signed(op_b);

  always_comb
  begin
    case (res_i.op)
      calc_isa_pkg::OP_ADD: int_data_o = res_i.rs1 + op_b;
      calc_isa_pkg::OP_SUB: int_data_o = res_i.rs1 - op_b;
      calc_isa_pkg::OP_AND: int_data_o = res_i.rs1 & op_b;
      calc_isa_pkg::OP_OR:  int_data_o = res_i.rs1 | op_b;
      calc_isa_pkg::OP_XOR: int_data_o = res_i.rs1 ^ op_b;
      calc_isa_pkg::OP_SLT: int_data_o = calc_isa_pkg::calc_data_t'(slt);
      calc_isa_pkg::OP_SLL: int_data_o = res_i.rs1 << shamt;
      calc_isa_pkg::OP_SRL: int_data_o = res_i.rs1 >> shamt;
      // Multiply result comes from the mul pipe
      default:              int_data_o = '0;
    endcase
  end

endmodule

// ==== common/calc_pipe_pkg.sv ====
// ========================================
// Pipeline packet types
// Dispatch packet, stage info, forwarding
// slot and writeback packet
// ========================================

package calc_pipe_pkg;

  // Dispatched instruction with register file operands
  typedef struct packed
  {
    logic                         valid;
    calc_isa_pkg::calc_op_e       op;
    logic                         use_imm;
    calc_isa_pkg::calc_reg_addr_t rs1_addr;
    calc_isa_pkg::calc_reg_addr_t rs2_addr;
    calc_isa_pkg::calc_reg_addr_t rd_addr;
    calc_isa_pkg::calc_data_t     rs1;
    calc_isa_pkg::calc_data_t     rs2;
    calc_isa_pkg::calc_data_t     imm;
    logic                         rd_w_v;
  } calc_dispatch_s;

  // Control info carried down the completion pipe
  typedef struct packed
  {
    logic                         valid;
    logic                         int_v;
    logic                         mul_v;
    logic                         rd_w_v;
    calc_isa_pkg::calc_reg_addr_t rd_addr;
  } calc_stage_info_s;

  // One forwarding slot, rd_v already qualified
  typedef struct packed
  {
    logic                         rd_v;
    calc_isa_pkg::calc_reg_addr_t rd_addr;
    calc_isa_pkg::calc_data_t     rd_data;
  } calc_fwd_s;

  // Register file write port
  typedef struct packed
  {
    logic                         rd_w_v;
    calc_isa_pkg::calc_reg_addr_t rd_addr;
    calc_isa_pkg::calc_data_t     rd_data;
  } calc_wb_s;

endpackage

// ==== common/calc_isa_pkg.sv ====
// ========================================
// ISA level types
// Data word, register index and the
// operation encoding
// ========================================

`include "calc_macros.svh"

package calc_isa_pkg;

  // Architectural data word
  typedef logic [`CALC_DATA_W-1:0] calc_data_t;

  // Register file index, register 0 reads as zero
  typedef logic [`CALC_REG_ADDR_W-1:0] calc_reg_addr_t;

  // Operations, shifts use the low 5 bits of the second operand
  typedef enum logic [3:0]
  {
    OP_ADD = 4'd0,
    OP_SUB = 4'd1,
    OP_AND = 4'd2,
    OP_OR  = 4'd3,
    OP_XOR = 4'd4,
    OP_SLT = 4'd5,
    OP_SLL = 4'd6,
    OP_SRL = 4'd7,
    OP_MUL = 4'd8
  } calc_op_e;

endpackage

// ==== common/calc_macros.svh ====
// ========================================
// Calculator back end parameters
// Datapath and register index widths,
// completion stage count, writeback stage
// ========================================

`ifndef CALC_MACROS_SVH
`define CALC_MACROS_SVH

// Datapath widths
`define CALC_DATA_W 32
`define CALC_REG_ADDR_W 5

// Completion pipe depth, one forwarding slot per stage
`define CALC_STAGES 3

// Stage whose next-state value feeds the writeback register
`define CALC_WB_STAGE 2

`endif
